//--- order_book.f
+incdir+include
logic/ob_pkg.sv
logic/order_intake.sv
logic/order_store.sv
logic/best_price_scan.sv
logic/order_book.sv
tb/tb_order_book.sv

//--- Bender.yml
package:
  name: order_book

sources:
  - logic/ob_pkg.sv
  - logic/order_intake.sv
  - logic/order_store.sv
  - logic/best_price_scan.sv
  - logic/order_book.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/tb_order_book.sv

//--- include/order_book_model.svh
/* reference model of the order book, included inside the testbench module
   predict_order() once per order, then compare status and book_bid, book_ask of book_shown */
`ifndef ORDER_BOOK_MODEL_SVH
`define ORDER_BOOK_MODEL_SVH

    bit                         book_valid [2][ob_pkg::NUM_STOCKS][ob_pkg::BOOK_DEPTH];
    logic [ob_pkg::PRICE_W-1:0] book_price [2][ob_pkg::NUM_STOCKS][ob_pkg::BOOK_DEPTH];
    logic [ob_pkg::QTY_W-1:0]   book_qty   [2][ob_pkg::NUM_STOCKS][ob_pkg::BOOK_DEPTH];
    logic [ob_pkg::ID_W-1:0]    book_id    [2][ob_pkg::NUM_STOCKS][ob_pkg::BOOK_DEPTH];
    logic [ob_pkg::PRICE_W-1:0] book_bid   [ob_pkg::NUM_STOCKS];
    logic [ob_pkg::PRICE_W-1:0] book_ask   [ob_pkg::NUM_STOCKS];
    int                         book_shown;

    function automatic void clear_book();
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < ob_pkg::NUM_STOCKS; k++) begin
                for (int n = 0; n < ob_pkg::BOOK_DEPTH; n++) begin
                    book_valid[s][k][n] = 1'b0;
                end
            end
        end
        for (int k = 0; k < ob_pkg::NUM_STOCKS; k++) begin
            book_bid[k] = ob_pkg::BID_EMPTY;
            book_ask[k] = ob_pkg::ASK_EMPTY;
        end
        book_shown = 0;
    endfunction

    // best price of one side after every add, cancel or execute
    function automatic void rescan_side(bit side, int stock);
        logic [ob_pkg::PRICE_W-1:0] best;
        best = side ? ob_pkg::BID_EMPTY : ob_pkg::ASK_EMPTY;
        for (int n = 0; n < ob_pkg::BOOK_DEPTH; n++) begin
            if (book_valid[side][stock][n] && side && book_price[side][stock][n] > best) begin
                best = book_price[side][stock][n];
            end
            if (book_valid[side][stock][n] && !side && book_price[side][stock][n] < best) begin
                best = book_price[side][stock][n];
            end
        end
        if (side) begin
            book_bid[stock] = best;
        end else begin
            book_ask[stock] = best;
        end
        book_shown = stock;
    endfunction

    function automatic logic [1:0] predict_order(logic [1:0] op, bit side, int stock,
                                                 logic [ob_pkg::PRICE_W-1:0] p,
                                                 logic [ob_pkg::QTY_W-1:0] q,
                                                 logic [ob_pkg::ID_W-1:0] oid);
        int         slot;
        logic [1:0] st;
        slot = -1;
        if (op == ob_pkg::OP_ADD) begin
            for (int n = ob_pkg::BOOK_DEPTH - 1; n >= 0; n--) begin
                if (!book_valid[side][stock][n]) begin
                    slot = n;
                end
            end
            st = (slot < 0) ? ob_pkg::ST_BOOK_FULL : ob_pkg::ST_OK;
            if (slot >= 0) begin
                book_valid[side][stock][slot] = 1'b1;
                book_price[side][stock][slot] = p;
                book_qty[side][stock][slot]   = q;
                book_id[side][stock][slot]    = oid;
            end
        end else if (op == ob_pkg::OP_CANCEL || op == ob_pkg::OP_EXECUTE) begin
            for (int n = ob_pkg::BOOK_DEPTH - 1; n >= 0; n--) begin
                if (book_valid[side][stock][n] && book_id[side][stock][n] == oid) begin
                    slot = n;
                end
            end
            st = (slot < 0) ? ob_pkg::ST_NOT_FOUND : ob_pkg::ST_OK;
            if (slot >= 0 && op == ob_pkg::OP_EXECUTE && book_qty[side][stock][slot] > q) begin
                book_qty[side][stock][slot] = book_qty[side][stock][slot] - q;
            end else if (slot >= 0) begin
                book_valid[side][stock][slot] = 1'b0;
            end
        end else begin
            return ob_pkg::ST_BAD_TYPE;
        end
        rescan_side(side, stock);
        return st;
    endfunction

`endif

//--- tb/tb_order_book.sv
/* testbench for the order book with LCG driven orders and result stalls
   checked against the reference model in the included header */
`default_nettype none
`timescale 1ns/1ns

module tb_order_book;

    localparam int MAX_STALL  = 6;
    // adds, full side, cancel, execute, bad type, back-pressure
    localparam int NUM_ORDERS = 24 + 9 + 12 + 12 + 6 + 30;
    localparam int TIMEOUT    = NUM_ORDERS * (2 * ob_pkg::BOOK_DEPTH + 8)
                                + NUM_ORDERS * MAX_STALL + 10;

    logic                       i_clk;
    logic                       i_reset_n;
    logic                       i_order_valid;
    logic                       o_order_ready;
    logic [1:0]                 i_order_type;
    logic                       i_side;
    logic [ob_pkg::STOCK_W-1:0] i_stock_id;
    logic [ob_pkg::PRICE_W-1:0] i_price;
    logic [ob_pkg::QTY_W-1:0]   i_quantity;
    logic [ob_pkg::ID_W-1:0]    i_order_id;
    logic                       o_result_valid;
    logic                       i_result_ready;
    logic [1:0]                 o_status;
    logic [ob_pkg::PRICE_W-1:0] o_best_bid;
    logic [ob_pkg::PRICE_W-1:0] o_best_ask;

    logic [31:0]        seed = 32'hcabe_37c9;
    logic [31:0]        next_id = 32'd1;
    int                 cycles = 0;
    int                 errors = 0;
    int                 checks = 0;
    int                 tests = 0;
    int                 errors_before = 0;
    int                 accepted = 0;
    int                 delivered = 0;
    logic [31:0]        known_id [$];
    bit                 known_side [$];
    int                 known_stock [$];

`include "order_book_model.svh"

    order_book u_dut (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_order_valid  (i_order_valid),
        .o_order_ready  (o_order_ready),
        .i_order_type   (i_order_type),
        .i_side         (i_side),
        .i_stock_id     (i_stock_id),
        .i_price        (i_price),
        .i_quantity     (i_quantity),
        .i_order_id     (i_order_id),
        .o_result_valid (o_result_valid),
        .i_result_ready (i_result_ready),
        .o_status       (o_status),
        .o_best_bid     (o_best_bid),
        .o_best_ask     (o_best_ask)
    );

    always #4 i_clk = ~i_clk;

    // handshake counters and the run limit
    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (i_order_valid && o_order_ready) begin
            accepted = accepted + 1;
        end
        if (o_result_valid && i_result_ready) begin
            delivered = delivered + 1;
        end
        if (cycles > TIMEOUT) begin
            $display("timeout: the DUT did not finish all orders within %0d cycles", TIMEOUT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed >> 8;
    endfunction

    // most results are taken at once and some wait a few cycles
    function automatic int pick_stall();
        int r;
        r = next_rand() % 16;
        if (r < 11) begin
            return 0;
        end
        return r - 10;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic run_order(input logic [1:0] op, input bit side, input int stock,
                             input logic [31:0] price, input logic [15:0] qty,
                             input logic [31:0] oid, input int stall);
        logic [1:0]  exp_status;
        logic [31:0] exp_bid;
        logic [31:0] exp_ask;
        exp_status = predict_order(op, side, stock, price, qty, oid);
        exp_bid    = book_bid[book_shown];
        exp_ask    = book_ask[book_shown];
        @(negedge i_clk);
        while (!o_order_ready) begin
            @(negedge i_clk);
        end
        i_order_valid = 1'b1;
        i_order_type  = op;
        i_side        = side;
        i_stock_id    = stock[ob_pkg::STOCK_W-1:0];
        i_price       = price;
        i_quantity    = qty;
        i_order_id    = oid;
        @(negedge i_clk);
        i_order_valid  = 1'b0;
        i_result_ready = (stall == 0);
        while (!o_result_valid) begin
            @(negedge i_clk);
        end
        compare_value("o_status", o_status, exp_status);
        compare_value("o_best_bid", o_best_bid, exp_bid);
        compare_value("o_best_ask", o_best_ask, exp_ask);
        compare_value("o_order_ready", o_order_ready, 0);
        // held result must not move
        repeat (stall) begin
            @(negedge i_clk);
            compare_value("o_result_valid", o_result_valid, 1);
            compare_value("o_status", o_status, exp_status);
            compare_value("o_best_bid", o_best_bid, exp_bid);
            compare_value("o_best_ask", o_best_ask, exp_ask);
            compare_value("o_order_ready", o_order_ready, 0);
        end
        i_result_ready = 1'b1;
        @(negedge i_clk);
        compare_value("o_result_valid", o_result_valid, 0);
        compare_value("o_order_ready", o_order_ready, 1);
        checks = checks + 1;
        if (delivered != accepted) begin
            errors = errors + 1;
            $display("at %0t the DUT delivered %0d results for %0d accepted orders",
                     $time, delivered, accepted);
        end
    endtask

    task automatic add_order(input bit side, input int stock, input logic [15:0] qty,
                             input int stall);
        logic [31:0] price;
        if (side) begin
            price = 32'd1000 + next_rand() % 200;
        end else begin
            price = 32'd1100 + next_rand() % 200;
        end
        known_id.push_back(next_id);
        known_side.push_back(side);
        known_stock.push_back(stock);
        next_id = next_id + 1;
        run_order(ob_pkg::OP_ADD, side, stock, price, qty, known_id[$], stall);
    endtask

    task automatic end_test(input string name);
        tests = tests + 1;
        $display("test %s finished with %0d errors", name, errors - errors_before);
        errors_before = errors;
    endtask

    initial begin
        int          idx;
        int          stk;
        int          stall;
        bit          sd;
        logic [1:0]  op;
        logic [31:0] oid;
        clear_book();
        i_clk          = 1'b0;
        i_reset_n      = 1'b0;
        i_order_valid  = 1'b0;
        i_order_type   = 2'd0;
        i_side         = 1'b0;
        i_stock_id     = '0;
        i_price        = '0;
        i_quantity     = '0;
        i_order_id     = '0;
        i_result_ready = 1'b1;
        repeat (5) @(negedge i_clk);
        i_reset_n = 1'b1;
        @(negedge i_clk);
        compare_value("o_order_ready", o_order_ready, 1);
        compare_value("o_result_valid", o_result_valid, 0);

        repeat (24) begin
            sd  = next_rand() % 2;
            stk = next_rand() % ob_pkg::NUM_STOCKS;
            add_order(sd, stk, 1 + next_rand() % 500, pick_stall());
        end
        end_test("reset_and_adds");

        // stock 3 sell side runs past its depth
        repeat (ob_pkg::BOOK_DEPTH + 1) begin
            add_order(1'b0, 3, 1 + next_rand() % 500, pick_stall());
        end
        end_test("full_side");

        repeat (4) begin
            idx = next_rand() % known_id.size();
            run_order(ob_pkg::OP_CANCEL, known_side[idx], known_stock[idx], 0, 0,
                      known_id[idx], pick_stall());
            run_order(ob_pkg::OP_CANCEL, known_side[idx], known_stock[idx], 0, 0,
                      known_id[idx], pick_stall());
        end
        repeat (4) begin
            sd  = next_rand() % 2;
            stk = next_rand() % ob_pkg::NUM_STOCKS;
            run_order(ob_pkg::OP_CANCEL, sd, stk, 0, 0, 32'hf000_0000 | next_rand(),
                      pick_stall());
        end
        end_test("cancel");

        repeat (2) begin
            sd  = next_rand() % 2;
            stk = next_rand() % 3;
            oid = next_id;
            add_order(sd, stk, 16'd100, pick_stall());
            run_order(ob_pkg::OP_EXECUTE, sd, stk, 0, 1 + next_rand() % 99, oid, pick_stall());
            run_order(ob_pkg::OP_CANCEL, sd, stk, 0, 0, oid, pick_stall());
            oid = next_id;
            add_order(sd, stk, 16'd100, pick_stall());
            run_order(ob_pkg::OP_EXECUTE, sd, stk, 0, 100 + next_rand() % 100, oid,
                      pick_stall());
            run_order(ob_pkg::OP_CANCEL, sd, stk, 0, 0, oid, pick_stall());
        end
        end_test("execute");

        repeat (3) begin
            stk = next_rand() % ob_pkg::NUM_STOCKS;
            run_order(2'd3, 1'b1, stk, 32'd5000, 16'd1, next_id, pick_stall());
        end
        // unknown cancels rescan each stock and expose its prices
        for (int k = 0; k < 3; k++) begin
            run_order(ob_pkg::OP_CANCEL, k % 2, k, 0, 0, 32'hffff_ff00 + k, pick_stall());
        end
        end_test("bad_type");

        repeat (30) begin
            op    = next_rand() % 4;
            sd    = next_rand() % 2;
            stk   = next_rand() % ob_pkg::NUM_STOCKS;
            stall = 1 + next_rand() % MAX_STALL;
            if (op == ob_pkg::OP_ADD) begin
                add_order(sd, stk, 1 + next_rand() % 500, stall);
            end else begin
                idx = next_rand() % known_id.size();
                run_order(op, known_side[idx], known_stock[idx], 0, next_rand() % 300,
                          known_id[idx], stall);
            end
        end
        end_test("back_pressure");

        // an idle stretch must bring no further result
        repeat (2 * ob_pkg::BOOK_DEPTH) @(negedge i_clk);
        checks = checks + 1;
        if (delivered != NUM_ORDERS) begin
            errors = errors + 1;
            $display("the DUT delivered %0d results for %0d orders", delivered, NUM_ORDERS);
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/order_book.sv
/* limit order book top level for a few stocks
   order channel in, result with status and best bid and ask out */
`default_nettype none
`timescale 1ns/1ns

module order_book (
    input  wire                          i_clk,
    input  wire                          i_reset_n,
    input  wire                          i_order_valid,
    output logic                         o_order_ready,
    input  wire  [1:0]                   i_order_type,
    input  wire                          i_side,
    input  wire  [ob_pkg::STOCK_W-1:0]   i_stock_id,
    input  wire  [ob_pkg::PRICE_W-1:0]   i_price,
    input  wire  [ob_pkg::QTY_W-1:0]     i_quantity,
    input  wire  [ob_pkg::ID_W-1:0]      i_order_id,
    output logic                         o_result_valid,
    input  wire                          i_result_ready,
    output logic [1:0]                   o_status,
    output logic [ob_pkg::PRICE_W-1:0]   o_best_bid,
    output logic [ob_pkg::PRICE_W-1:0]   o_best_ask
);

    logic                       start_add;
    logic                       start_cancel;
    logic                       start_execute;
    logic                       side;
    logic [ob_pkg::STOCK_W-1:0] stock_id;
    logic [ob_pkg::PRICE_W-1:0] price;
    logic [ob_pkg::QTY_W-1:0]   quantity;
    logic [ob_pkg::ID_W-1:0]    order_id;
    logic                       op_done;
    logic [1:0]                 op_status;
    logic [ob_pkg::SLOT_W-1:0]  rd_slot;
    logic [ob_pkg::PRICE_W-1:0] rd_price;
    logic                       rd_valid;
    logic                       scan_done;

    order_intake u_intake (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_order_valid   (i_order_valid),
        .o_order_ready   (o_order_ready),
        .i_order_type    (i_order_type),
        .i_side          (i_side),
        .i_stock_id      (i_stock_id),
        .i_price         (i_price),
        .i_quantity      (i_quantity),
        .i_order_id      (i_order_id),
        .i_result_ready  (i_result_ready),
        .i_op_done       (op_done),
        .i_op_status     (op_status),
        .i_scan_done     (scan_done),
        .o_start_add     (start_add),
        .o_start_cancel  (start_cancel),
        .o_start_execute (start_execute),
        .o_side          (side),
        .o_stock_id      (stock_id),
        .o_price         (price),
        .o_quantity      (quantity),
        .o_order_id      (order_id),
        .o_result_valid  (o_result_valid),
        .o_status        (o_status)
    );

    order_store u_store (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_start_add     (start_add),
        .i_start_cancel  (start_cancel),
        .i_start_execute (start_execute),
        .i_side          (side),
        .i_stock_id      (stock_id),
        .i_price         (price),
        .i_quantity      (quantity),
        .i_order_id      (order_id),
        .i_rd_slot       (rd_slot),
        .o_op_done       (op_done),
        .o_op_status     (op_status),
        .o_rd_price      (rd_price),
        .o_rd_valid      (rd_valid)
    );

    best_price_scan u_scan (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_op_done   (op_done),
        .i_side      (side),
        .i_stock_id  (stock_id),
        .i_rd_price  (rd_price),
        .i_rd_valid  (rd_valid),
        .o_rd_slot   (rd_slot),
        .o_scan_done (scan_done),
        .o_best_bid  (o_best_bid),
        .o_best_ask  (o_best_ask)
    );

endmodule

`default_nettype wire

//--- logic/best_price_scan.sv
/* walks every slot of the side just touched and stores its best price per stock
   started by op_done, ends with a one cycle scan_done */
`default_nettype none
`timescale 1ns/1ns

module best_price_scan (
    input  wire                          i_clk,
    input  wire                          i_reset_n,
    input  wire                          i_op_done,
    input  wire                          i_side,
    input  wire  [ob_pkg::STOCK_W-1:0]   i_stock_id,
    input  wire  [ob_pkg::PRICE_W-1:0]   i_rd_price,
    input  wire                          i_rd_valid,
    output logic [ob_pkg::SLOT_W-1:0]    o_rd_slot,
    output logic                         o_scan_done,
    output logic [ob_pkg::PRICE_W-1:0]   o_best_bid,
    output logic [ob_pkg::PRICE_W-1:0]   o_best_ask
);

    logic [ob_pkg::PRICE_W-1:0] bid_reg [ob_pkg::NUM_STOCKS];
    logic [ob_pkg::PRICE_W-1:0] ask_reg [ob_pkg::NUM_STOCKS];
    logic [ob_pkg::PRICE_W-1:0] best;
    logic [ob_pkg::PRICE_W-1:0] next_best;
    logic [ob_pkg::STOCK_W-1:0] shown_stock;
    logic                       scanning;
    logic                       better;

    // highest price wins on the buy side, lowest on the sell side
    always_comb begin
        if (i_side == ob_pkg::SIDE_BUY) begin
            better = i_rd_price > best;
        end else begin
            better = i_rd_price < best;
        end
        next_best = (i_rd_valid && better) ? i_rd_price : best;
    end

    always_ff @(posedge i_clk) begin
        if (i_op_done) begin
            best <= (i_side == ob_pkg::SIDE_BUY) ? ob_pkg::BID_EMPTY : ob_pkg::ASK_EMPTY;
        end else if (scanning) begin
            best <= next_best;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            scanning    <= 1'b0;
            o_rd_slot   <= '0;
            o_scan_done <= 1'b0;
            shown_stock <= '0;
            for (int k = 0; k < ob_pkg::NUM_STOCKS; k++) begin
                bid_reg[k] <= ob_pkg::BID_EMPTY;
                ask_reg[k] <= ob_pkg::ASK_EMPTY;
            end
        end else begin
            o_scan_done <= 1'b0;
            if (i_op_done) begin
                scanning  <= 1'b1;
                o_rd_slot <= '0;
            end else if (scanning) begin
                o_rd_slot <= o_rd_slot + 1'b1;
                // on the last slot the winner goes straight into the stock register
                if (int'(o_rd_slot) == ob_pkg::BOOK_DEPTH - 1) begin
                    scanning    <= 1'b0;
                    o_scan_done <= 1'b1;
                    shown_stock <= i_stock_id;
                    if (i_side == ob_pkg::SIDE_BUY) begin
                        bid_reg[i_stock_id] <= next_best;
                    end else begin
                        ask_reg[i_stock_id] <= next_best;
                    end
                end
            end
        end
    end

    assign o_best_bid = bid_reg[shown_stock];
    assign o_best_ask = ask_reg[shown_stock];

endmodule

`default_nettype wire

//--- logic/order_store.sv
/* resting orders for every stock and side, one slot per order with a valid flag
   handles add, and cancel or execute by a one slot per cycle id search */
`default_nettype none
`timescale 1ns/1ns

module order_store (
    input  wire                          i_clk,
    input  wire                          i_reset_n,
    input  wire                          i_start_add,
    input  wire                          i_start_cancel,
    input  wire                          i_start_execute,
    input  wire                          i_side,
    input  wire  [ob_pkg::STOCK_W-1:0]   i_stock_id,
    input  wire  [ob_pkg::PRICE_W-1:0]   i_price,
    input  wire  [ob_pkg::QTY_W-1:0]     i_quantity,
    input  wire  [ob_pkg::ID_W-1:0]      i_order_id,
    input  wire  [ob_pkg::SLOT_W-1:0]    i_rd_slot,
    output logic                         o_op_done,
    output logic [1:0]                   o_op_status,
    output logic [ob_pkg::PRICE_W-1:0]   o_rd_price,
    output logic                         o_rd_valid
);

    // slot address is {side, stock, slot}
    logic [ob_pkg::PRICE_W-1:0] slot_price [2*ob_pkg::NUM_STOCKS*ob_pkg::BOOK_DEPTH];
    logic [ob_pkg::QTY_W-1:0]   slot_qty   [2*ob_pkg::NUM_STOCKS*ob_pkg::BOOK_DEPTH];
    logic [ob_pkg::ID_W-1:0]    slot_id    [2*ob_pkg::NUM_STOCKS*ob_pkg::BOOK_DEPTH];
    logic [2*ob_pkg::NUM_STOCKS*ob_pkg::BOOK_DEPTH-1:0] slot_valid;

    logic [ob_pkg::STOCK_W+ob_pkg::SLOT_W:0] wr_idx;
    logic [ob_pkg::STOCK_W+ob_pkg::SLOT_W:0] srch_idx;
    logic [ob_pkg::STOCK_W+ob_pkg::SLOT_W:0] rd_idx;
    logic [ob_pkg::SLOT_W-1:0]               free_slot;
    logic [ob_pkg::SLOT_W-1:0]               srch_ptr;
    logic                                    free_found;
    logic                                    searching;
    logic                                    is_exec;
    logic                                    srch_active;
    logic                                    srch_exec;
    logic                                    srch_hit;
    logic                                    fill;

    // lowest free slot of the held side
    always_comb begin
        free_found = 1'b0;
        free_slot  = '0;
        for (int s = ob_pkg::BOOK_DEPTH - 1; s >= 0; s--) begin
            if (!slot_valid[{i_side, i_stock_id, s[ob_pkg::SLOT_W-1:0]}]) begin
                free_found = 1'b1;
                free_slot  = s[ob_pkg::SLOT_W-1:0];
            end
        end
    end

    assign wr_idx   = {i_side, i_stock_id, free_slot};
    assign srch_idx = {i_side, i_stock_id, srch_ptr};
    assign rd_idx   = {i_side, i_stock_id, i_rd_slot};

    // slot 0 is tested in the start cycle itself
    assign srch_active = i_start_cancel || i_start_execute || searching;
    assign srch_exec   = i_start_execute || (searching && is_exec);
    assign srch_hit    = srch_active && slot_valid[srch_idx]
                         && (slot_id[srch_idx] == i_order_id);
    // execute of at least the resting quantity removes the order
    assign fill        = !srch_exec || (slot_qty[srch_idx] <= i_quantity);

    assign o_rd_price = slot_price[rd_idx];
    assign o_rd_valid = slot_valid[rd_idx];

    always_ff @(posedge i_clk) begin
        if (i_start_add && free_found) begin
            slot_price[wr_idx] <= i_price;
            slot_qty[wr_idx]   <= i_quantity;
            slot_id[wr_idx]    <= i_order_id;
        end
        if (srch_hit && !fill) begin
            slot_qty[srch_idx] <= slot_qty[srch_idx] - i_quantity;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            slot_valid  <= '0;
            searching   <= 1'b0;
            is_exec     <= 1'b0;
            srch_ptr    <= '0;
            o_op_done   <= 1'b0;
            o_op_status <= ob_pkg::ST_OK;
        end else begin
            o_op_done <= 1'b0;

            if (i_start_add) begin
                o_op_done <= 1'b1;
                if (free_found) begin
                    slot_valid[wr_idx] <= 1'b1;
                    o_op_status        <= ob_pkg::ST_OK;
                end else begin
                    o_op_status <= ob_pkg::ST_BOOK_FULL;
                end
            end

            if (i_start_cancel || i_start_execute) begin
                is_exec <= i_start_execute;
            end

            if (srch_hit) begin
                o_op_done   <= 1'b1;
                o_op_status <= ob_pkg::ST_OK;
                searching   <= 1'b0;
                srch_ptr    <= '0;
                if (fill) begin
                    slot_valid[srch_idx] <= 1'b0;
                end
            end else if (srch_active) begin
                if (int'(srch_ptr) == ob_pkg::BOOK_DEPTH - 1) begin
                    o_op_done   <= 1'b1;
                    o_op_status <= ob_pkg::ST_NOT_FOUND;
                    searching   <= 1'b0;
                    srch_ptr    <= '0;
                end else begin
                    searching <= 1'b1;
                    srch_ptr  <= srch_ptr + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/order_intake.sv
/* order channel front end: accepts one order, pulses the store, holds the result
   until the trading side takes it */
`default_nettype none
`timescale 1ns/1ns

module order_intake (
    input  wire                          i_clk,
    input  wire                          i_reset_n,
    input  wire                          i_order_valid,
    output logic                         o_order_ready,
    input  wire  [1:0]                   i_order_type,
    input  wire                          i_side,
    input  wire  [ob_pkg::STOCK_W-1:0]   i_stock_id,
    input  wire  [ob_pkg::PRICE_W-1:0]   i_price,
    input  wire  [ob_pkg::QTY_W-1:0]     i_quantity,
    input  wire  [ob_pkg::ID_W-1:0]      i_order_id,
    input  wire                          i_result_ready,
    input  wire                          i_op_done,
    input  wire  [1:0]                   i_op_status,
    input  wire                          i_scan_done,
    output logic                         o_start_add,
    output logic                         o_start_cancel,
    output logic                         o_start_execute,
    output logic                         o_side,
    output logic [ob_pkg::STOCK_W-1:0]   o_stock_id,
    output logic [ob_pkg::PRICE_W-1:0]   o_price,
    output logic [ob_pkg::QTY_W-1:0]     o_quantity,
    output logic [ob_pkg::ID_W-1:0]      o_order_id,
    output logic                         o_result_valid,
    output logic [1:0]                   o_status
);

    // idle is neither working nor holding
    logic working;
    logic holding;
    logic accept;

    assign o_order_ready = !working && !holding;
    assign accept        = i_order_valid && o_order_ready;

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_side     <= i_side;
            o_stock_id <= i_stock_id;
            o_price    <= i_price;
            o_quantity <= i_quantity;
            o_order_id <= i_order_id;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            working         <= 1'b0;
            holding         <= 1'b0;
            o_result_valid  <= 1'b0;
            o_start_add     <= 1'b0;
            o_start_cancel  <= 1'b0;
            o_start_execute <= 1'b0;
            o_status        <= ob_pkg::ST_OK;
        end else begin
            o_start_add     <= 1'b0;
            o_start_cancel  <= 1'b0;
            o_start_execute <= 1'b0;

            if (accept) begin
                case (i_order_type)
                    ob_pkg::OP_ADD: begin
                        o_start_add <= 1'b1;
                        working     <= 1'b1;
                    end
                    ob_pkg::OP_CANCEL: begin
                        o_start_cancel <= 1'b1;
                        working        <= 1'b1;
                    end
                    ob_pkg::OP_EXECUTE: begin
                        o_start_execute <= 1'b1;
                        working         <= 1'b1;
                    end
                    default: begin
                        // no store access and the result follows a cycle later
                        o_status <= ob_pkg::ST_BAD_TYPE;
                        holding  <= 1'b1;
                    end
                endcase
            end

            if (working) begin
                if (i_op_done) begin
                    o_status <= i_op_status;
                end
                if (i_scan_done) begin
                    working        <= 1'b0;
                    holding        <= 1'b1;
                    o_result_valid <= 1'b1;
                end
            end

            if (holding) begin
                if (!o_result_valid) begin
                    o_result_valid <= 1'b1;
                end else if (i_result_ready) begin
                    holding        <= 1'b0;
                    o_result_valid <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/ob_pkg.sv
/* sizes, order codes and result codes shared by the order book RTL and its testbench
   refer to them as ob_pkg::name */
`default_nettype none

package ob_pkg;

    localparam int NUM_STOCKS = 4;
    localparam int BOOK_DEPTH = 8;
    localparam int STOCK_W    = 2;
    localparam int SLOT_W     = 3;
    localparam int PRICE_W    = 32;
    localparam int QTY_W      = 16;
    localparam int ID_W       = 32;

    // order type codes where code 3 is invalid
    localparam logic [1:0] OP_ADD     = 2'd0;
    localparam logic [1:0] OP_CANCEL  = 2'd1;
    localparam logic [1:0] OP_EXECUTE = 2'd2;

    // side bit of a buy order and 0 means sell
    localparam logic SIDE_BUY = 1'b1;

    localparam logic [1:0] ST_OK        = 2'd0;
    localparam logic [1:0] ST_NOT_FOUND = 2'd1;
    localparam logic [1:0] ST_BOOK_FULL = 2'd2;
    localparam logic [1:0] ST_BAD_TYPE  = 2'd3;

    // reported when a side holds no orders
    localparam logic [PRICE_W-1:0] BID_EMPTY = '0;
    localparam logic [PRICE_W-1:0] ASK_EMPTY = '1;

endpackage

`default_nettype wire
